// ==== hw/cic_cfg.svh ====
`ifndef CIC_CFG_SVH
`define CIC_CFG_SVH

// decimation factor, power of two from 4 to 64.
`define CIC_RATE 8

// integrator and comb sections.
`define CIC_ORDER 4

`define CIC_IN_WIDTH 16   // converter sample width.
`define CIC_OUT_WIDTH 18  // width after decimation and after compensation.

// compensator weights, outer, inner and centre tap.
// 2*outer + 2*inner + centre = 2^17 for unity gain at DC.
`define COMP_COEF0 (-2048)
`define COMP_COEF1 (-8192)
`define COMP_COEF2 151552

`endif

// ==== hw/cicPkg.sv ====
`default_nettype none

`include "cic_cfg.svh"

package cicPkg;

    // one converter sample, valid is a level.
    typedef struct packed {
        logic                            valid;
        logic signed [`CIC_IN_WIDTH-1:0] data;
    } adcSampleT;

    // decimated sample.
    // strobe is a single-cycle pulse and data counts only while it is high.
    typedef struct packed {
        logic                             strobe;
        logic signed [`CIC_OUT_WIDTH-1:0] data;
    } decimSampleT;

endpackage

`default_nettype wire

// ==== hw/cicDecimator.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cic_cfg.svh"

module cicDecimator (
    input  logic                clk,
    input  logic                reset,
    input  cicPkg::adcSampleT   adcIn,
    output cicPkg::decimSampleT decim
);

    localparam int rateBits = $clog2(`CIC_RATE);
    localparam int growth = `CIC_ORDER * rateBits;  // bit growth of R^N gain.
    localparam int accWidth = `CIC_IN_WIDTH + growth;

    logic        [rateBits-1:0] rateCount;
    logic                       groupDone;  // last input of a group just absorbed.
    logic signed [accWidth-1:0] sampleExt;
    logic signed [accWidth-1:0] integ     [`CIC_ORDER];
    logic signed [accWidth-1:0] integNext [`CIC_ORDER];
    logic signed [accWidth-1:0] combPrev  [`CIC_ORDER];
    logic signed [accWidth-1:0] combOut   [`CIC_ORDER];

    assign sampleExt = {{growth{adcIn.data[`CIC_IN_WIDTH-1]}}, adcIn.data};

    // integrator cascade, all sections advance together on a valid.
    // accumulators wrap, the combs undo the overflow.
    always_comb begin
        integNext[0] = integ[0] + sampleExt;
        for (int i = 1; i < `CIC_ORDER; i++) begin
            integNext[i] = integ[i] + integNext[i-1];
        end
    end

    // comb cascade at the low rate.
    always_comb begin
        combOut[0] = integ[`CIC_ORDER-1] - combPrev[0];
        for (int i = 1; i < `CIC_ORDER; i++) begin
            combOut[i] = combOut[i-1] - combPrev[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rateCount <= '0;
            groupDone <= 1'b0;
            for (int i = 0; i < `CIC_ORDER; i++) begin
                integ[i] <= '0;
            end
        end else begin
            groupDone <= 1'b0;
            if (adcIn.valid) begin
                for (int i = 0; i < `CIC_ORDER; i++) begin
                    integ[i] <= integNext[i];
                end
                rateCount <= rateCount + 1'b1;  // wraps at the rate.
                groupDone <= (rateCount == rateBits'(`CIC_RATE - 1));
            end
        end
    end

    // one registered comb step per group, strobe two cycles after the last valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CIC_ORDER; i++) begin
                combPrev[i] <= '0;
            end
            decim <= '0;
        end else begin
            decim.strobe <= groupDone;
            if (groupDone) begin
                combPrev[0] <= integ[`CIC_ORDER-1];
                for (int i = 1; i < `CIC_ORDER; i++) begin
                    combPrev[i] <= combOut[i-1];
                end
                // drop the gain, keep 18 bits with the input left-justified.
                decim.data <= combOut[`CIC_ORDER-1][accWidth-1 -: `CIC_OUT_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cicComp.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cic_cfg.svh"

module cicComp (
    input  logic                clk,
    input  logic                reset,
    input  cicPkg::decimSampleT decim,
    output cicPkg::decimSampleT compOut,
    output logic                satFlag
);

    localparam int dataMsb = `CIC_OUT_WIDTH - 1;
    localparam int coefWidth = 19;  // centre weight needs 19 bits signed.
    localparam int sumWidth = `CIC_OUT_WIDTH + 1;
    localparam int prodWidth = sumWidth + coefWidth;
    localparam int finalWidth = `CIC_OUT_WIDTH + 2;
    localparam int gainShift = `CIC_OUT_WIDTH - 1;  // weights sum to 2^17.

    localparam logic signed [coefWidth-1:0] coef0 = `COMP_COEF0;
    localparam logic signed [coefWidth-1:0] coef1 = `COMP_COEF1;
    localparam logic signed [coefWidth-1:0] coef2 = `COMP_COEF2;

    localparam logic signed [finalWidth-1:0] posLimit = finalWidth'((1 << gainShift) - 1);
    localparam logic signed [finalWidth-1:0] negLimit = -posLimit;

    // tap k holds the sample k strobes before the incoming one.
    logic signed [`CIC_OUT_WIDTH-1:0] tapLine [1:8];
    logic signed [sumWidth-1:0]       outerSum;
    logic signed [sumWidth-1:0]       innerSum;
    logic signed [`CIC_OUT_WIDTH-1:0] centreTap;
    logic signed [prodWidth-1:0]      outerProd;
    logic signed [prodWidth-1:0]      innerProd;
    logic signed [prodWidth-1:0]      centreProd;
    logic signed [finalWidth-1:0]     finalSum;
    logic                             overHigh;
    logic                             overLow;

    // delay line and symmetric pre-adds, odd taps carry zero weight.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k <= 8; k++) begin
                tapLine[k] <= '0;
            end
            outerSum  <= '0;
            innerSum  <= '0;
            centreTap <= '0;
        end else if (decim.strobe) begin
            tapLine[1] <= decim.data;
            for (int k = 2; k <= 8; k++) begin
                tapLine[k] <= tapLine[k-1];
            end
            outerSum  <= {decim.data[dataMsb], decim.data} + {tapLine[8][dataMsb], tapLine[8]};
            innerSum  <= {tapLine[2][dataMsb], tapLine[2]} + {tapLine[6][dataMsb], tapLine[6]};
            centreTap <= tapLine[4];
        end
    end

    // product stage, one clock behind the pre-adds.
    always_ff @(posedge clk) begin
        if (reset) begin
            outerProd  <= '0;
            innerProd  <= '0;
            centreProd <= '0;
        end else begin
            outerProd  <= outerSum * coef0;
            innerProd  <= innerSum * coef1;
            centreProd <= centreTap * coef2;
        end
    end

    // scale back by 2^17 and add at 20 bits.
    assign finalSum = outerProd[gainShift +: finalWidth]
                    + innerProd[gainShift +: finalWidth]
                    + centreProd[gainShift +: finalWidth];

    assign overHigh = (finalSum > posLimit);
    assign overLow  = (finalSum < negLimit);  // symmetric clamp.

    // previous frame is captured on the following strobe.
    always_ff @(posedge clk) begin
        if (reset) begin
            compOut <= '0;
            satFlag <= 1'b0;
        end else begin
            compOut.strobe <= decim.strobe;
            satFlag        <= decim.strobe && (overHigh || overLow);
            if (decim.strobe) begin
                if (overHigh) begin
                    compOut.data <= posLimit[dataMsb:0];
                end else if (overLow) begin
                    compOut.data <= negLimit[dataMsb:0];
                end else begin
                    compOut.data <= finalSum[dataMsb:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/cicFilter.sv ====
`timescale 1ns/1ns
`default_nettype none

module cicFilter (
    input  logic                clk,
    input  logic                reset,
    input  cicPkg::adcSampleT   adcIn,
    output cicPkg::decimSampleT compOut,
    output logic                satFlag
);

    import cicPkg::*;

    decimSampleT decim;  // low-rate samples between the stages.

    // fourth-order CIC, rate reduction.
    cicDecimator decimator (
        .clk   (clk),
        .reset (reset),
        .adcIn (adcIn),
        .decim (decim)
    );

    // droop compensation and clamp to 18 bits.
    cicComp compensator (
        .clk     (clk),
        .reset   (reset),
        .decim   (decim),
        .compOut (compOut),
        .satFlag (satFlag)
    );

endmodule

`default_nettype wire

// ==== verif/cicFilterTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cic_cfg.svh"

module cicFilterTb;

    import cicPkg::*;

    localparam int satLimit = (1 << (`CIC_OUT_WIDTH - 1)) - 1;
    localparam int drainLimit = 24;  // cycles allowed for the last strobe.

    logic        clk;
    logic        reset;
    adcSampleT   adcIn;
    decimSampleT compOut;
    logic        satFlag;

    int          caseKind[$];
    int          caseAmp[$];
    int          caseCount[$];
    int          caseSpacing[$];
    int          caseExpected[$];
    int          caseTol[$];
    logic        casesLoaded;
    logic [31:0] rngState;
    int          valueErrors;
    int          otherErrors;

    // per-case monitor state.
    int          curCase;
    int          curKind;
    int          curAmp;
    int          validCount;
    int          strobeCount;
    int          flagCount;
    int          lastFlagIdx;
    logic        dataVaries;
    logic signed [`CIC_OUT_WIDTH-1:0] firstData;
    decimSampleT lastOut;

    cicFilter dut (
        .clk     (clk),
        .reset   (reset),
        .adcIn   (adcIn),
        .compOut (compOut),
        .satFlag (satFlag)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkSample(input decimSampleT got, input int expected, input int tol,
                               input string what);
        int gotVal;
        int diff;
        gotVal = int'($signed(got.data));
        diff = gotVal - expected;
        if (diff > tol || diff < -tol) begin
            valueErrors++;
            $display("FAIL %0t: %s reads %0d, expected %0d +/- %0d",
                     $time, what, gotVal, expected, tol);
        end
    endtask

    task automatic checkFlag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            valueErrors++;
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic checkCount(input int got, input int lo, input int hi, input string what);
        if (got < lo || got > hi) begin
            valueErrors++;
            $display("FAIL %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic loadCases();
        int    fd;
        int    got;
        int    kind, amp, cnt, spc, expVal, tol;
        string line;
        fd = $fopen("verif/cicFilterCases.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open the case file verif/cicFilterCases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%d %d %d %d %d %d", kind, amp, cnt, spc, expVal, tol);
                    if (got == 6) begin
                        caseKind.push_back(kind);
                        caseAmp.push_back(amp);
                        caseCount.push_back(cnt);
                        caseSpacing.push_back(spc);
                        caseExpected.push_back(expVal);
                        caseTol.push_back(tol);
                    end else if (got > 0) begin
                        otherErrors++;
                        $display("malformed case line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (caseKind.size() == 0) begin
            otherErrors++;
            $display("no test cases were read");
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        reset = 1'b1;
        adcIn = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic runCase(input int idx);
        int kind, amp, count, spacing, sample, leadZeros, outTarget, waited;
        kind = caseKind[idx];
        amp = caseAmp[idx];
        count = caseCount[idx];
        spacing = caseSpacing[idx];
        applyReset();
        // nothing may come out before the first valid.
        repeat (4) begin
            @(negedge clk);
            checkFlag(compOut.strobe, 1'b0, $sformatf("case %0d strobe after reset", idx));
            checkFlag(satFlag, 1'b0, $sformatf("case %0d satFlag after reset", idx));
            checkSample(compOut, 0, 0, $sformatf("case %0d data after reset", idx));
        end
        curCase = idx;
        curKind = kind;
        curAmp = amp;
        validCount = 0;
        strobeCount = 0;
        flagCount = 0;
        lastFlagIdx = -1;
        dataVaries = 1'b0;
        leadZeros = (kind == 1 || kind == 2) ? count / 4 : 0;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            case (kind)
                0: sample = amp;
                1, 2: sample = (i < leadZeros) ? 0 : amp;
                default: begin
                    rngState = xorshift32(rngState);
                    sample = int'(rngState % 32'(2 * amp)) - amp;
                end
            endcase
            adcIn.valid = 1'b1;
            adcIn.data = 16'(sample);
            repeat (spacing - 1) begin
                @(posedge clk);
                #1;
                adcIn.valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        adcIn.valid = 1'b0;
        outTarget = validCount / `CIC_RATE;
        waited = 0;
        while (strobeCount < outTarget && waited < drainLimit) begin
            @(posedge clk);
            waited++;
        end
        @(negedge clk);
        #1;
        curKind = -1;
        if (strobeCount == 0) begin
            otherErrors++;
            $display("case %0d produced no output strobe", idx);
        end else begin
            checkCount(strobeCount, outTarget - 2, outTarget,
                       $sformatf("case %0d output strobes", idx));
            if (kind == 3) begin
                checkFlag(flagCount > 0, 1'b0, $sformatf("case %0d noise satFlag", idx));
                checkFlag(dataVaries, 1'b1, $sformatf("case %0d noise output varies", idx));
            end else begin
                checkSample(lastOut, caseExpected[idx], caseTol[idx],
                            $sformatf("case %0d settled value", idx));
                checkFlag(flagCount > 0, kind == 2, $sformatf("case %0d satFlag seen", idx));
                checkFlag(lastFlagIdx > strobeCount - 8, 1'b0,
                          $sformatf("case %0d satFlag after settling", idx));
            end
        end
    endtask

    // outputs are sampled on the falling edge.
    always @(negedge clk) begin
        if (adcIn.valid) validCount++;
        if (satFlag && !compOut.strobe) begin
            otherErrors++;
            $display("satFlag pulsed at %0t without an output strobe", $time);
        end
        if (compOut.strobe) begin
            strobeCount++;
            if (strobeCount == 1) firstData = compOut.data;
            else if (compOut.data != firstData) dataVaries = 1'b1;
            lastOut = compOut;
            if (satFlag) begin
                flagCount++;
                lastFlagIdx = strobeCount;
            end
            if (curKind == 2 && satFlag)
                checkSample(compOut, (curAmp > 0) ? satLimit : -satLimit, 0,
                            $sformatf("case %0d clamped output", curCase));
            if (curKind == 3)
                checkSample(compOut, 0, satLimit, $sformatf("case %0d noise range", curCase));
        end
    end

    // run length bound from the case table.
    initial begin
        longint budget;
        wait (casesLoaded);
        budget = 0;
        foreach (caseCount[i]) budget += longint'(caseCount[i]) * caseSpacing[i] * 4;
        budget = 2 * budget + longint'(caseCount.size()) * 64 * 4 + 400;
        #(budget);
        $display("watchdog expired after %0d ns, the run did not finish", budget);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        adcIn = '0;
        casesLoaded = 1'b0;
        rngState = 32'd8;  // xorshift seed.
        valueErrors = 0;
        otherErrors = 0;
        curCase = 0;
        curKind = -1;
        curAmp = 0;
        loadCases();
        casesLoaded = 1'b1;
        foreach (caseKind[i]) runCase(i);
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cicFilter.f ====
+incdir+hw
hw/cicPkg.sv
hw/cicDecimator.sv
hw/cicComp.sv
hw/cicFilter.sv
verif/cicFilterTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the cicFilter testbench with Verilator.
# Run from anywhere; paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f cicFilter.f \
    --top-module cicFilterTb \
    --Mdir obj_dir \
    -o cicFilterSim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cicFilterSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/cicFilterCases.txt ====
# kind amplitude inputs spacing expected tolerance
# kind 0 dc level, 1 step from zero, 2 full-scale step, 3 xorshift noise
0 1000 256 1 4000 2
0 -5000 256 3 -20000 2
0 12345 256 1 49380 2
0 -12345 256 3 -49380 2
0 24000 256 1 96000 2
0 -28000 160 5 -112000 2
0 0 300 2 0 2
1 8000 256 1 32000 2
1 -16000 256 2 -64000 2
1 4096 256 3 16384 2
2 32767 256 1 131068 2
2 -32767 256 3 -131068 2
3 16384 512 1 0 0
3 16384 256 2 0 0
